// File: src.f
hw/log_num_pkg.sv
hw/log_op_pkg.sv
hw/exp_if.sv
hw/log2_unit.sv
hw/log_combine.sv
hw/exp2_unit.sv
hw/log_ctrl.sv
hw/log_muldiv.sv
tb/tb_log_muldiv.sv

// File: Makefile
TOP := tb_log_muldiv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failures found" sim.log || ! grep -q "All tests passed!" sim.log; then \
	  echo "Simulation failed"; \
	  exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir sim.log

// File: tb/tb_log_muldiv.sv
`timescale 1ns/100ps

module tb_log_muldiv import log_num_pkg::*, log_op_pkg::*;;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 10;
  localparam int LATENCY    = 7;
  localparam int MAX_GAP    = 3;
  localparam int N_MUL      = 200;
  localparam int N_DIV      = 200;
  localparam int N_BIG      = 60;
  localparam int N_ZERO     = 40;
  localparam int N_BURST    = 4;
  localparam int N_GAP      = 80;
  localparam int N_REQ      = N_MUL + N_DIV + N_BIG + N_ZERO + N_BURST + N_GAP;
  // A request can occupy up to MAX_GAP+1 cycles in the gapped test
  localparam int WATCHDOG_NS = (N_REQ + LATENCY + 2 * RST_CYCLES) * CLK_PERIOD * (MAX_GAP + 1)
                               + 400;

  logic     clk;
  logic     rst;
  logic     start;
  op_t      op;
  operand_t a;
  operand_t b;
  operand_t result;
  logic     result_valid;
  logic     overflow;
  logic     div_zero;

  int seed;
  int cycle_cnt  = 0;
  int errors     = 0;
  int n_requests = 0;
  int n_results  = 0;

  // Expected responses in request order
  operand_t exp_value_q [$];
  logic     exp_ovf_q [$];
  logic     exp_dz_q [$];
  int       exp_cycle_q [$];
  string    desc_q [$];

  frac_t log_tab [256];
  frac_t exp_tab [256];

  log_muldiv i_log_muldiv (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .op           (op),
    .a            (a),
    .b            (b),
    .result       (result),
    .result_valid (result_valid),
    .overflow     (overflow),
    .div_zero     (div_zero)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Both lookup tables truncate 256 times the exact value
  initial begin
    for (int i = 0; i < 256; i++) begin
      log_tab[frac_t'(i)] = frac_t'($rtoi(256.0 * $ln(1.0 + real'(i) / 256.0) / $ln(2.0)));
      exp_tab[frac_t'(i)] = frac_t'($rtoi(256.0 * (2.0 ** (real'(i) / 256.0) - 1.0)));
    end
  end

  // Leading-one index in the integer part, table-corrected mantissa below it
  function automatic int log2_model(input operand_t x);
    int          lead;
    logic [23:0] ext;
    lead = 0;
    for (int i = 0; i < 16; i++) begin
      if (x[i]) lead = i;
    end
    ext = {x, 8'h00} >> lead;
    return lead * 256 + int'(log_tab[ext[7:0]]);
  endfunction

  function automatic operand_t model_result(input op_t o, input operand_t x, input operand_t y,
                                            output logic ovf, output logic dz);
    int          sum;
    frac_t       frac;
    logic [31:0] scaled;
    ovf = 1'b0;
    dz  = 1'b0;
    if (o == OP_DIV && y == '0) begin
      dz = 1'b1;
      return '1;
    end
    if (x == '0 || y == '0) return '0;
    if (o == OP_MUL) sum = log2_model(x) + log2_model(y);
    else sum = log2_model(x) - log2_model(y);
    // Below 1.0 the antilog truncates to zero, and 4096 stands for 16.0
    if (sum < 0) return '0;
    if (sum >= 4096) begin
      ovf = 1'b1;
      return '1;
    end
    frac   = frac_t'(sum);
    scaled = (32'd256 + 32'(exp_tab[frac])) << (sum / 256);
    return operand_t'(scaled >> 8);
  endfunction

  function automatic operand_t rand_operand(input int bits);
    operand_t v;
    v = operand_t'($random(seed)) & operand_t'((32'd1 << bits) - 1);
    if (v == '0) v = operand_t'(1);
    return v;
  endfunction

  function automatic int rand_width();
    return 1 + ($random(seed) & 15);
  endfunction

  task automatic check_result(input string what, input operand_t got, input operand_t want);
    if (got !== want) begin
      $display("Fail at %0t: %s gave result 0x%04h, expected 0x%04h", $realtime, what, got, want);
      errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic want);
    if (got !== want) begin
      $display("Fail at %0t: %s flag is %b, expected %b", $realtime, what, got, want);
      errors++;
    end
  endtask

  task automatic check_cycle(input string what, input int got, input int want);
    if (got != want) begin
      $display("Fail at %0t: %s arrived in cycle %0d, expected %0d", $realtime, what, got, want);
      errors++;
    end
  endtask

  task automatic send(input op_t o, input operand_t x, input operand_t y);
    logic     ovf;
    logic     dz;
    operand_t val;
    @(posedge clk);
    #1;
    start = 1'b1;
    op    = o;
    a     = x;
    b     = y;
    val   = model_result(o, x, y, ovf, dz);
    exp_value_q.push_back(val);
    exp_ovf_q.push_back(ovf);
    exp_dz_q.push_back(dz);
    exp_cycle_q.push_back(cycle_cnt + LATENCY);
    desc_q.push_back($sformatf("%s 0x%04h 0x%04h", (o == OP_MUL) ? "mul" : "div", x, y));
    n_requests++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      start = 1'b0;
    end
  endtask

  function automatic void flush_expected();
    exp_value_q.delete();
    exp_ovf_q.delete();
    exp_dz_q.delete();
    exp_cycle_q.delete();
    desc_q.delete();
  endfunction

  task automatic finish_test(input string name, input int err_before);
    int waited;
    waited = 0;
    idle(1);
    while (exp_value_q.size() != 0 && waited < LATENCY + 3) begin
      @(negedge clk);
      waited++;
    end
    if (exp_value_q.size() != 0) begin
      $display("Missing results: %0d requests never returned a result", exp_value_q.size());
      errors++;
      flush_expected();
    end
    $display("Test %s finished with %0d errors", name, errors - err_before);
  endtask

  // Outputs change on the rising edge and are sampled on the falling edge
  always @(negedge clk) begin
    if (!rst && result_valid) begin
      n_results++;
      if (exp_value_q.size() == 0) begin
        $display("Unexpected result_valid at %0t with no request outstanding", $realtime);
        errors++;
      end else begin
        check_result(desc_q[0], result, exp_value_q.pop_front());
        check_flag({desc_q[0], " overflow"}, overflow, exp_ovf_q.pop_front());
        check_flag({desc_q[0], " div_zero"}, div_zero, exp_dz_q.pop_front());
        check_cycle(desc_q[0], cycle_cnt, exp_cycle_q.pop_front());
        void'(desc_q.pop_front());
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

  initial begin
    int err0;
    $timeformat(-9, 1, " ns", 0);
    seed  = 87;
    rst   = 1'b1;
    start = 1'b0;
    op    = OP_MUL;
    a     = '0;
    b     = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    // Eight-bit operands keep every product below 16.0 in the log domain
    err0 = errors;
    for (int i = 0; i < N_MUL; i++) send(OP_MUL, rand_operand(8), rand_operand(8));
    finish_test("random_mul", err0);

    err0 = errors;
    for (int i = 0; i < N_DIV; i++) begin
      send(OP_DIV, rand_operand(rand_width()), rand_operand(rand_width()));
    end
    finish_test("random_div", err0);

    // Both leading ones at bit 8 or above push the sum to 16.0 or more
    err0 = errors;
    for (int i = 0; i < N_BIG; i++) begin
      send(OP_MUL, rand_operand(16) | operand_t'(16'h0100), rand_operand(16) | operand_t'(16'h0100));
    end
    finish_test("large_mul", err0);

    err0 = errors;
    for (int i = 0; i < N_ZERO; i++) begin
      case (i % 4)
        0: send(OP_MUL, operand_t'(0), rand_operand(16));
        1: send(OP_MUL, rand_operand(16), operand_t'(0));
        2: send(OP_DIV, operand_t'(0), rand_operand(16));
        default: send(OP_DIV, (i % 8 == 3) ? operand_t'(0) : rand_operand(16), operand_t'(0));
      endcase
    end
    finish_test("zero_operands", err0);

    // Requests still in the pipeline are lost when reset hits
    err0 = errors;
    for (int i = 0; i < N_BURST; i++) send(OP_MUL, rand_operand(16), rand_operand(16));
    @(posedge clk);
    #1;
    start = 1'b0;
    rst   = 1'b1;
    n_requests -= exp_value_q.size();
    flush_expected();
    repeat (RST_CYCLES) begin
      @(negedge clk);
      check_flag("result_valid in reset", result_valid, 1'b0);
      check_flag("overflow in reset", overflow, 1'b0);
      check_flag("div_zero in reset", div_zero, 1'b0);
    end
    @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (LATENCY + 1) begin
      @(negedge clk);
      check_flag("result_valid after reset", result_valid, 1'b0);
      check_flag("overflow after reset", overflow, 1'b0);
      check_flag("div_zero after reset", div_zero, 1'b0);
    end
    for (int i = 0; i < N_GAP; i++) begin
      send((($random(seed) & 1) == 1) ? OP_DIV : OP_MUL,
           (($random(seed) & 7) == 0) ? operand_t'(0) : rand_operand(rand_width()),
           (($random(seed) & 7) == 0) ? operand_t'(0) : rand_operand(rand_width()));
      idle($random(seed) & MAX_GAP);
    end
    finish_test("gapped_with_reset", err0);

    if (n_results != n_requests) begin
      $display("Result count mismatch: %0d requests issued, %0d results received",
               n_requests, n_results);
      errors++;
    end
    $display("Summary: %0d requests, %0d results, %0d errors", n_requests, n_results, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: hw/log_muldiv.sv
`timescale 1ns/100ps

// Approximate unsigned multiply and divide in the log domain.
// One request per clock; a start in cycle n returns its result with
// result_valid in cycle n+7, in request order.
module log_muldiv import log_num_pkg::*, log_op_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  input  op_t      op,
  input  operand_t a,
  input  operand_t b,
  output operand_t result,
  output logic     result_valid,
  output logic     overflow,
  output logic     div_zero
);

  logic     log_valid;
  operand_t x_a;
  operand_t x_b;
  op_t      op_aligned;

  logic valid_a;
  log_t log_a;
  logic valid_b;
  log_t log_b;

  logic     exp_valid;
  operand_t exp_value;
  logic     exp_sat;

  exp_if exp_bus ();

  log_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .op           (op),
    .a            (a),
    .b            (b),
    .log_valid    (log_valid),
    .x_a          (x_a),
    .x_b          (x_b),
    .op_aligned   (op_aligned),
    .exp_valid    (exp_valid),
    .exp_value    (exp_value),
    .exp_sat      (exp_sat),
    .result       (result),
    .result_valid (result_valid),
    .overflow     (overflow),
    .div_zero     (div_zero)
  );

  log2_unit u_log_a (
    .clk     (clk),
    .rst     (rst),
    .valid_i (log_valid),
    .x       (x_a),
    .log2    (log_a),
    .valid_o (valid_a)
  );

  log2_unit u_log_b (
    .clk     (clk),
    .rst     (rst),
    .valid_i (log_valid),
    .x       (x_b),
    .log2    (log_b),
    .valid_o (valid_b)
  );

  log_combine u_combine (
    .clk     (clk),
    .rst     (rst),
    .valid_a (valid_a),
    .log_a   (log_a),
    .valid_b (valid_b),
    .log_b   (log_b),
    .op      (op_aligned),
    .exp     (exp_bus.src)
  );

  exp2_unit u_exp2 (
    .clk   (clk),
    .rst   (rst),
    .exp   (exp_bus.dst),
    .valid (exp_valid),
    .value (exp_value),
    .sat   (exp_sat)
  );

endmodule

// File: hw/log_ctrl.sv
`timescale 1ns/100ps

// Request intake and result stage of the log-domain unit.
// Zero operands are replaced by 1 on the way in, and their original state
// rides a delay line next to the datapath so that the zero rules can be
// applied when the antilog value comes back.
module log_ctrl import log_num_pkg::*, log_op_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  input  op_t      op,
  input  operand_t a,
  input  operand_t b,
  output logic     log_valid,
  output operand_t x_a,
  output operand_t x_b,
  output op_t      op_aligned,
  input  logic     exp_valid,
  input  operand_t exp_value,
  input  logic     exp_sat,
  output operand_t result,
  output logic     result_valid,
  output logic     overflow,
  output logic     div_zero
);

  logic a_zero;
  logic b_zero;

  logic [DATA_LAT-1:0] start_dly;
  logic [DATA_LAT-1:0] a_zero_dly;
  logic [DATA_LAT-1:0] b_zero_dly;
  op_t                 op_dly [DATA_LAT];

  op_t  op_end;
  logic div_by_zero;
  logic any_zero;

  assign a_zero = (a == '0);
  assign b_zero = (b == '0);

  // log2(1) is exactly 0, which keeps the datapath well defined
  assign log_valid = start;
  assign x_a       = a_zero ? operand_t'(1) : a;
  assign x_b       = b_zero ? operand_t'(1) : b;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start_dly <= '0;
    end else begin
      start_dly <= {start_dly[DATA_LAT-2:0], start};
    end
  end

  always_ff @(posedge clk) begin
    a_zero_dly <= {a_zero_dly[DATA_LAT-2:0], a_zero};
    b_zero_dly <= {b_zero_dly[DATA_LAT-2:0], b_zero};
    op_dly[0]  <= op;
    for (int i = 1; i < DATA_LAT; i++) begin
      op_dly[i] <= op_dly[i-1];
    end
  end

  // Tap after LOG2_LAT stages lines the opcode up with both logarithms
  assign op_aligned = op_dly[LOG2_LAT-1];

  assign op_end      = op_dly[DATA_LAT-1];
  assign div_by_zero = (op_end == OP_DIV) && b_zero_dly[DATA_LAT-1];
  assign any_zero    = a_zero_dly[DATA_LAT-1] || b_zero_dly[DATA_LAT-1];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result_valid <= 1'b0;
      overflow     <= 1'b0;
      div_zero     <= 1'b0;
    end else begin
      result_valid <= exp_valid;
      div_zero     <= exp_valid && div_by_zero;
      overflow     <= exp_valid && !div_by_zero && !any_zero && exp_sat;
    end
  end

  // Division by zero wins over the other zero cases
  always_ff @(posedge clk) begin
    if (div_by_zero) begin
      result <= '1;
    end else if (any_zero) begin
      result <= '0;
    end else begin
      result <= exp_value;
    end
  end

  // The sideband must leave the delay line together with the antilog value
  sideband_aligned: assert property (
    @(posedge clk) disable iff (rst) exp_valid == start_dly[DATA_LAT-1]
  ) else $error("log_ctrl sideband out of step with the datapath");

endmodule

// File: hw/exp2_unit.sv
`timescale 1ns/100ps

// Two-stage antilog.
// The fraction selects a table entry that restores the mantissa 1.f, and
// the integer part shifts it into place. Values out of range saturate.
module exp2_unit import log_num_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  exp_if.dst       exp,
  output logic     valid,
  output operand_t value,
  output logic     sat
);

  logic     s1_valid;
  logic     s1_over;
  logic     s1_under;
  frac_t    s1_mant;
  exp_int_t s1_int;

  logic [OPERAND_W+FRAC_BITS-1:0] shifted;

  // Entry f holds the fraction of 2^(f/256) without the implied leading 1
  frac_t exp_lut [2**FRAC_BITS];

  initial begin
    for (int f = 0; f < 2**FRAC_BITS; f++) begin
      exp_lut[f] = frac_t'($rtoi((2.0 ** (real'(f) / 2.0**FRAC_BITS) - 1.0)
                                 * 2.0**FRAC_BITS));
    end
  end

  // Stage 1 does the table lookup
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1_over  <= 1'b0;
      s1_under <= 1'b0;
    end else begin
      s1_valid <= exp.valid;
      s1_over  <= exp.over;
      s1_under <= exp.under;
    end
  end

  always_ff @(posedge clk) begin
    s1_mant <= exp_lut[exp.frac];
    s1_int  <= exp.int_part;
  end

  // 1.f scaled by 2^int_part, still with FRAC_BITS fraction bits below
  assign shifted = {{(OPERAND_W-1){1'b0}}, 1'b1, s1_mant} << s1_int;

  // Stage 2 applies the shift and the saturation
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid <= 1'b0;
      sat   <= 1'b0;
    end else begin
      valid <= s1_valid;
      sat   <= s1_valid && s1_over;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_over) begin
      value <= '1;
    end else if (s1_under) begin
      // Anything below 1.0 truncates to zero
      value <= '0;
    end else begin
      value <= shifted[FRAC_BITS +: OPERAND_W];
    end
  end

endmodule

// File: hw/log_combine.sv
`timescale 1ns/100ps

// Adds two logarithms for a multiply or subtracts them for a divide,
// and classifies the range of the result for the antilog stage
module log_combine import log_num_pkg::*, log_op_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      valid_a,
  input  log_t      log_a,
  input  logic      valid_b,
  input  log_t      log_b,
  input  op_t       op,
  exp_if.src        exp
);

  log_sum_t ext_a;
  log_sum_t ext_b;
  log_sum_t sum;
  logic     sum_neg;
  logic     sum_big;

  // Both logarithms are unsigned and get zero extended
  assign ext_a = log_sum_t'(log_a);
  assign ext_b = log_sum_t'(log_b);

  assign sum = (op == OP_MUL) ? ext_a + ext_b : ext_a - ext_b;

  // Bit INT_BITS+FRAC_BITS is the 16s place of a positive sum
  assign sum_neg = sum[$bits(log_sum_t)-1];
  assign sum_big = !sum_neg && sum[INT_BITS+FRAC_BITS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      exp.valid <= 1'b0;
      exp.over  <= 1'b0;
      exp.under <= 1'b0;
    end else begin
      exp.valid <= valid_a;
      exp.over  <= valid_a && sum_big;
      exp.under <= valid_a && sum_neg;
    end
  end

  always_ff @(posedge clk) begin
    exp.int_part <= sum[FRAC_BITS +: INT_BITS];
    exp.frac     <= sum[FRAC_BITS-1:0];
  end

  // Both converters are started together and have equal latency
  operands_aligned: assert property (
    @(posedge clk) disable iff (rst) valid_a == valid_b
  ) else $error("log_combine operands arrived in different cycles");

  range_flags_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(exp.over && exp.under)
  ) else $error("log_combine flagged both overflow and underflow");

endmodule

// File: hw/log2_unit.sv
`timescale 1ns/100ps

// Pipelined log2 of an unsigned nonzero operand.
// The result is the leading-one index followed by a table-corrected
// mantissa built from the bits just below the leading one.
module log2_unit import log_num_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     valid_i,
  input  operand_t x,
  output log_t     log2,
  output logic     valid_o
);

  logic stage1_valid;
  logic stage2_valid;

  operand_t x_reg;

  logic [INT_BITS-1:0] lead_idx;
  logic [INT_BITS-1:0] lead_idx_reg;

  logic [OPERAND_W+FRAC_BITS-1:0] x_ext;

  frac_t lin_mant;
  frac_t lin_mant_reg;

  // Maps a linear mantissa m/256 to the fraction of log2(1 + m/256)
  frac_t mant_lut [2**FRAC_BITS];

  initial begin
    for (int i = 0; i < 2**FRAC_BITS; i++) begin
      mant_lut[i] = frac_t'($rtoi($ln(1.0 + real'(i) / 2.0**FRAC_BITS) / $ln(2.0)
                                  * 2.0**FRAC_BITS));
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stage1_valid <= 1'b0;
      stage2_valid <= 1'b0;
      valid_o      <= 1'b0;
    end else begin
      stage1_valid <= valid_i;
      stage2_valid <= stage1_valid;
      valid_o      <= stage2_valid;
    end
  end

  // Operand, leading-one index with linear mantissa, and the final logarithm
  always_ff @(posedge clk) begin
    x_reg        <= x;
    lead_idx_reg <= lead_idx;
    lin_mant_reg <= lin_mant;
    log2         <= {lead_idx_reg, mant_lut[lin_mant_reg]};
  end

  // Priority encoder where the highest set bit wins
  always_comb begin
    lead_idx = '0;
    for (int i = 0; i < OPERAND_W; i++) begin
      if (x_reg[i]) begin
        lead_idx = INT_BITS'(i);
      end
    end
  end

  // Pad with zeros below the LSB so that short operands still yield a full
  // mantissa, then move the leading one up to bit FRAC_BITS
  assign x_ext    = {x_reg, {FRAC_BITS{1'b0}}} >> lead_idx;
  assign lin_mant = x_ext[FRAC_BITS-1:0];

  // The control block swaps zero operands for 1 before they get here
  nonzero_operand: assert property (
    @(posedge clk) disable iff (rst) valid_i |-> (x != '0)
  ) else $error("log2_unit got a zero operand");

endmodule

// File: hw/exp_if.sv
`timescale 1ns/100ps

// Combined logarithm handed from the combiner to the antilog stage.
// The value is split into its integer and fraction parts, and its range
// is already classified so the antilog stage only has to saturate.
interface exp_if import log_num_pkg::*;;

  logic     valid;
  exp_int_t int_part;
  frac_t    frac;
  // Combined value is 16.0 or more
  logic     over;
  // Combined value is below zero
  logic     under;

  modport src (
    output valid, int_part, frac, over, under
  );

  modport dst (
    input valid, int_part, frac, over, under
  );

endinterface

// File: hw/log_op_pkg.sv
// Operation codes and the latency of each pipeline section
package log_op_pkg;

  typedef enum logic {
    OP_MUL = 1'b0,
    OP_DIV = 1'b1
  } op_t;

  // Cycles from valid_i to valid_o of each datapath block
  localparam int LOG2_LAT    = 3;
  localparam int COMBINE_LAT = 1;
  localparam int EXP2_LAT    = 2;

  // Depth of the sideband delay line in the control block
  localparam int DATA_LAT = LOG2_LAT + COMBINE_LAT + EXP2_LAT;

endpackage

// File: hw/log_num_pkg.sv
// Number format of the log-domain datapath.
// Logarithms are unsigned fixed point with INT_BITS integer bits and
// FRAC_BITS fractional bits. The combined value of two logarithms gets
// one extra bit of range and a sign bit.
package log_num_pkg;

  // Operand and result width
  localparam int OPERAND_W = 16;

  // Fractional bits carried by every logarithm
  localparam int FRAC_BITS = 8;

  // Integer bits of a single-operand logarithm cover the index 0 to 15
  localparam int INT_BITS = 4;

  typedef logic [OPERAND_W-1:0] operand_t;

  // The leading-one index sits above the mantissa
  typedef logic [INT_BITS+FRAC_BITS-1:0] log_t;

  // The sum of two log_t values needs one more bit and the difference needs a sign
  typedef logic signed [INT_BITS+FRAC_BITS+1:0] log_sum_t;

  // Table index and table contents of the log and antilog lookups
  typedef logic [FRAC_BITS-1:0] frac_t;

  // Shift amount handed to the antilog stage
  typedef logic [INT_BITS-1:0] exp_int_t;

endpackage
